/* logic/muscle_pkg.sv */
`default_nettype none

package muscle_pkg;

    //////////////////////////////
    // fixed-point types
    //////////////////////////////

    // signed Q16.16 value
    typedef logic signed [31:0] q16_t;
    // unsigned spike count per step
    typedef logic [15:0] spike_t;

    localparam int Q_FRAC = 16;

    // muscle rest length, 1.0
    localparam q16_t REST_LENGTH = 32'sh0001_0000;

    // force rate constants
    // kse*kpe/b = 204.0
    localparam q16_t K_LENGTH = 32'sh00CC_0000;
    // kse = 136.0
    localparam q16_t K_VEL    = 32'sh0088_0000;
    // kse/b*(1+kpe/kse) ~ 4.22
    localparam q16_t K_FORCE  = 32'sh0004_3852;
    // activation gain ~ 2.72
    localparam q16_t K_ACT    = 32'sh0002_B852;

    // force-length breakpoints 0.5, 1.0 and 2.0
    localparam q16_t W_BP_LOW  = 32'sh0000_8000;
    localparam q16_t W_BP_MID  = 32'sh0001_0000;
    localparam q16_t W_BP_HIGH = 32'sh0002_0000;
    // polynomial coefficients -4, 8, -3 and 2
    localparam q16_t W_NEG4  = 32'shFFFC_0000;
    localparam q16_t W_EIGHT = 32'sh0008_0000;
    localparam q16_t W_NEG3  = 32'shFFFD_0000;
    localparam q16_t W_TWO   = 32'sh0002_0000;

    //////////////////////////////
    // shared structs
    //////////////////////////////

    // h = b1*x1 + c1*h1 - c2*h2
    typedef struct packed {
        q16_t b1;
        q16_t c1;
        q16_t c2;
    } twitch_coef_t;

    // muscle length and lengthening velocity
    typedef struct packed {
        q16_t pos;
        q16_t vel;
    } limb_t;

    // one enable per pipeline stage, integ drives the force update
    typedef struct packed {
        logic twitch;
        logic weight;
        logic integ;
    } stage_en_t;

    // full 64 bit product, arithmetic shift floors toward minus infinity
    function automatic q16_t q_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        logic signed [63:0] shifted;
        prod = 64'(a) * 64'(b);
        shifted = prod >>> Q_FRAC;
        return shifted[31:0];
    endfunction

endpackage

`default_nettype wire

/* logic/sample_history.sv */
`default_nettype none

// two-deep delay line of past samples, advanced only on shift_i
module sample_history #(
    parameter type T_SAMPLE = logic [31:0]
) (
    input  wire     clk,
    input  wire     reset,
    input  wire     shift_i,
    input  T_SAMPLE sample_i,
    output T_SAMPLE prev1_o,
    output T_SAMPLE prev2_o
);

    // newest sample in prev1, the one before it in prev2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev1_o <= '0;
            prev2_o <= '0;
        end else if (shift_i) begin
            prev2_o <= prev1_o;
            prev1_o <= sample_i;
        end
    end

endmodule

`default_nettype wire

/* logic/muscle_ctrl.sv */
`default_nettype none

module muscle_ctrl (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      step_i,
    input  muscle_pkg::limb_t        limb_i,
    input  wire                      cfg_load_i,
    input  muscle_pkg::q16_t         cfg_decay_i,
    input  muscle_pkg::q16_t         cfg_gain_i,
    output muscle_pkg::twitch_coef_t coef_o,
    output muscle_pkg::stage_en_t    stage_en_o,
    output muscle_pkg::limb_t        weight_limb_o,
    output muscle_pkg::limb_t        force_limb_o,
    output logic                     force_valid_o
);

    //////////////////////////////
    // twitch coefficients
    //////////////////////////////

    // b1 = gain*a, c1 = 2a, c2 = a*a
    // zero after reset so the filter stays silent until software loads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coef_o <= '0;
        end else if (cfg_load_i) begin
            coef_o.b1 <= muscle_pkg::q_mul(cfg_gain_i, cfg_decay_i);
            coef_o.c1 <= cfg_decay_i + cfg_decay_i;
            coef_o.c2 <= muscle_pkg::q_mul(cfg_decay_i, cfg_decay_i);
        end
    end

    //////////////////////////////
    // step sequencing
    //////////////////////////////

    // step_i itself is stage 0 of the chain
    // bit 1 weight, bit 2 force, bit 3 result valid
    logic [3:1] step_dly;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_dly <= '0;
        end else begin
            step_dly <= {step_dly[2:1], step_i};
        end
    end

    always_comb begin
        stage_en_o.twitch = step_i;
        stage_en_o.weight = step_dly[1];
        stage_en_o.integ  = step_dly[2];
    end

    assign force_valid_o = step_dly[3];

    // limb travels with its step, one register per stage
    // each register only moves when its own step does
    always_ff @(posedge clk) begin
        if (step_i) begin
            weight_limb_o <= limb_i;
        end
        if (step_dly[1]) begin
            force_limb_o <= weight_limb_o;
        end
    end

endmodule

`default_nettype wire

/* logic/twitch_filter.sv */
`default_nettype none

// second order twitch response, z / (z - a)^2 as a difference equation
module twitch_filter #(
    parameter int SPIKE_SHIFT = 10
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      en_i,
    input  muscle_pkg::spike_t       spike_count_i,
    input  muscle_pkg::twitch_coef_t coef_i,
    output muscle_pkg::q16_t         h_o
);

    muscle_pkg::spike_t x1_cnt;
    muscle_pkg::q16_t   x1;
    muscle_pkg::q16_t   h1;
    muscle_pkg::q16_t   h2;
    muscle_pkg::q16_t   h_new;

    // raw spike counts, only the last one enters the equation
    sample_history #(
        .T_SAMPLE(muscle_pkg::spike_t)
    ) i_spike_hist (
        .clk     (clk),
        .reset   (reset),
        .shift_i (en_i),
        .sample_i(spike_count_i),
        .prev1_o (x1_cnt),
        .prev2_o ()
    );

    // past filter outputs, h1 doubles as the registered h
    sample_history #(
        .T_SAMPLE(muscle_pkg::q16_t)
    ) i_h_hist (
        .clk     (clk),
        .reset   (reset),
        .shift_i (en_i),
        .sample_i(h_new),
        .prev1_o (h1),
        .prev2_o (h2)
    );

    // each spike is worth 2^SPIKE_SHIFT lsb of q16
    assign x1 = muscle_pkg::q16_t'({16'd0, x1_cnt}) <<< SPIKE_SHIFT;

    // h = b1*x1 + c1*h1 - c2*h2, from the history before this step
    assign h_new = muscle_pkg::q_mul(coef_i.b1, x1)
                 + muscle_pkg::q_mul(coef_i.c1, h1)
                 - muscle_pkg::q_mul(coef_i.c2, h2);

    assign h_o = h1;

endmodule

`default_nettype wire

/* logic/length_weight.sv */
`default_nettype none

module length_weight (
    input  wire              clk,
    input  wire              reset,
    input  wire              en_i,
    input  muscle_pkg::q16_t pos_i,
    input  muscle_pkg::q16_t h_i,
    output muscle_pkg::q16_t activation_o
);

    muscle_pkg::q16_t x_sq;
    muscle_pkg::q16_t w_rise;
    muscle_pkg::q16_t w_fall;
    muscle_pkg::q16_t weight;

    //////////////////////////////
    // force-length curve
    //////////////////////////////

    always_comb begin
        x_sq = muscle_pkg::q_mul(pos_i, pos_i);
        // rising limb, -4x^2 + 8x - 3
        w_rise = muscle_pkg::q_mul(muscle_pkg::W_NEG4, x_sq)
               + muscle_pkg::q_mul(muscle_pkg::W_EIGHT, pos_i)
               + muscle_pkg::W_NEG3;
        // falling limb, -x^2 + 2x
        w_fall = muscle_pkg::q_mul(muscle_pkg::W_TWO, pos_i) - x_sq;
        // signed compare, breakpoints belong to the lower region
        if (pos_i <= muscle_pkg::W_BP_LOW) begin
            weight = '0;
        end else if (pos_i <= muscle_pkg::W_BP_MID) begin
            weight = w_rise;
        end else if (pos_i <= muscle_pkg::W_BP_HIGH) begin
            weight = w_fall;
        end else begin
            weight = '0;
        end
    end

    // weighted activation, held until the next step reaches this stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            activation_o <= '0;
        end else if (en_i) begin
            activation_o <= muscle_pkg::q_mul(weight, h_i);
        end
    end

endmodule

`default_nettype wire

/* logic/force_integrator.sv */
`default_nettype none

module force_integrator #(
    parameter int DT_SHIFT = 10
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               en_i,
    input  muscle_pkg::limb_t limb_i,
    input  muscle_pkg::q16_t  activation_i,
    output muscle_pkg::q16_t  force_o,
    output muscle_pkg::q16_t  activation_o
);

    muscle_pkg::q16_t stretch;
    muscle_pkg::q16_t len_term;
    muscle_pkg::q16_t vel_term;
    muscle_pkg::q16_t decay_term;
    muscle_pkg::q16_t act_term;
    muscle_pkg::q16_t d_force;

    //////////////////////////////
    // force rate
    //////////////////////////////

    // dT = 204*(x-x0) + 136*v - 4.22*T + 2.72*A
    always_comb begin
        stretch = limb_i.pos - muscle_pkg::REST_LENGTH;
        // passive spring only pulls once stretched past rest
        if (stretch[31]) begin
            len_term = '0;
        end else begin
            len_term = muscle_pkg::q_mul(muscle_pkg::K_LENGTH, stretch);
        end
        vel_term   = muscle_pkg::q_mul(muscle_pkg::K_VEL, limb_i.vel);
        decay_term = muscle_pkg::q_mul(muscle_pkg::K_FORCE, force_o);
        act_term   = muscle_pkg::q_mul(muscle_pkg::K_ACT, activation_i);
        d_force    = len_term + vel_term - decay_term + act_term;
    end

    //////////////////////////////
    // forward euler step
    //////////////////////////////

    // dt = 2^-DT_SHIFT, so the step is a plain arithmetic shift
    // activation is latched with T so both describe the same step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            force_o      <= '0;
            activation_o <= '0;
        end else if (en_i) begin
            force_o      <= force_o + (d_force >>> DT_SHIFT);
            activation_o <= activation_i;
        end
    end

endmodule

`default_nettype wire

/* logic/muscle_top.sv */
`default_nettype none

module muscle_top #(
    parameter int SPIKE_SHIFT = 10,
    parameter int DT_SHIFT    = 10
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                step_i,
    input  muscle_pkg::spike_t spike_count_i,
    input  muscle_pkg::limb_t  limb_i,
    input  wire                cfg_load_i,
    input  muscle_pkg::q16_t   cfg_decay_i,
    input  muscle_pkg::q16_t   cfg_gain_i,
    output logic               force_valid_o,
    output muscle_pkg::q16_t   force_o,
    output muscle_pkg::q16_t   activation_o
);

    muscle_pkg::twitch_coef_t coef;
    muscle_pkg::stage_en_t    stage_en;
    muscle_pkg::limb_t        weight_limb;
    muscle_pkg::limb_t        force_limb;
    muscle_pkg::q16_t         twitch_h;
    muscle_pkg::q16_t         weighted_act;

    //////////////////////////////
    // control
    //////////////////////////////

    muscle_ctrl i_muscle_ctrl (
        .clk          (clk),
        .reset        (reset),
        .step_i       (step_i),
        .limb_i       (limb_i),
        .cfg_load_i   (cfg_load_i),
        .cfg_decay_i  (cfg_decay_i),
        .cfg_gain_i   (cfg_gain_i),
        .coef_o       (coef),
        .stage_en_o   (stage_en),
        .weight_limb_o(weight_limb),
        .force_limb_o (force_limb),
        .force_valid_o(force_valid_o)
    );

    //////////////////////////////
    // datapath, twitch -> weight -> force
    //////////////////////////////

    twitch_filter #(.SPIKE_SHIFT(SPIKE_SHIFT)) i_twitch_filter (
        .clk          (clk),
        .reset        (reset),
        .en_i         (stage_en.twitch),
        .spike_count_i(spike_count_i),
        .coef_i       (coef),
        .h_o          (twitch_h)
    );

    length_weight i_length_weight (
        .clk         (clk),
        .reset       (reset),
        .en_i        (stage_en.weight),
        .pos_i       (weight_limb.pos),
        .h_i         (twitch_h),
        .activation_o(weighted_act)
    );

    // activation output comes from the last stage, aligned with force_o
    force_integrator #(.DT_SHIFT(DT_SHIFT)) i_force_integrator (
        .clk         (clk),
        .reset       (reset),
        .en_i        (stage_en.integ),
        .limb_i      (force_limb),
        .activation_i(weighted_act),
        .force_o     (force_o),
        .activation_o(activation_o)
    );

endmodule

`default_nettype wire

/* verification/muscle_model.svh */
`ifndef MUSCLE_MODEL_SVH
`define MUSCLE_MODEL_SVH

// 1.0 in q16.16
localparam muscle_pkg::q16_t ONE_Q = 32'sh0001_0000;
// 4.22 and 2.72 rounded to the nearest lsb
localparam muscle_pkg::q16_t M_K_FORCE = 32'sd276562;
localparam muscle_pkg::q16_t M_K_ACT   = 32'sd178258;

// what one step should report on its valid pulse
typedef struct packed {
    muscle_pkg::q16_t force_val;
    muscle_pkg::q16_t act_val;
} result_t;

// coefficients as last loaded
muscle_pkg::q16_t m_b1;
muscle_pkg::q16_t m_c1;
muscle_pkg::q16_t m_c2;
// filter memory and integrated force
muscle_pkg::spike_t m_x1;
muscle_pkg::q16_t   m_h1;
muscle_pkg::q16_t   m_h2;
muscle_pkg::q16_t   m_force;

// floor of the 64 bit product over 2^16 with only the low word kept
function automatic muscle_pkg::q16_t model_mul(input muscle_pkg::q16_t a,
                                               input muscle_pkg::q16_t b);
    longint prod;
    prod = longint'(a) * longint'(b);
    prod = prod >>> 16;
    return prod[31:0];
endfunction

function automatic void model_reset();
    m_b1    = '0;
    m_c1    = '0;
    m_c2    = '0;
    m_x1    = '0;
    m_h1    = '0;
    m_h2    = '0;
    m_force = '0;
endfunction

// b1 = gain*a, c1 = 2a, c2 = a^2
function automatic void model_load(input muscle_pkg::q16_t decay, input muscle_pkg::q16_t gain);
    m_b1 = model_mul(gain, decay);
    m_c1 = 2 * decay;
    m_c2 = model_mul(decay, decay);
endfunction

// zero outside (0.5, 2.0] and each breakpoint goes to the lower region
function automatic muscle_pkg::q16_t model_weight(input muscle_pkg::q16_t x);
    muscle_pkg::q16_t x_sq;
    x_sq = model_mul(x, x);
    if (x <= 32'sh0000_8000 || x > 32'sh0002_0000) begin
        return '0;
    end
    if (x <= ONE_Q) begin
        return -4 * x_sq + 8 * x - 3 * ONE_Q;
    end
    return 2 * x - x_sq;
endfunction

// one full step of twitch then weighting then the euler update
function automatic result_t model_step(input muscle_pkg::spike_t count,
                                       input muscle_pkg::q16_t pos,
                                       input muscle_pkg::q16_t vel);
    muscle_pkg::q16_t x_q;
    muscle_pkg::q16_t h;
    muscle_pkg::q16_t act;
    muscle_pkg::q16_t stretch;
    muscle_pkg::q16_t len_term;
    muscle_pkg::q16_t d_force;
    result_t          r;
    // the previous count scaled by 2^SPIKE_SHIFT drives this step's h
    x_q = int'(m_x1) * (1 << SPIKE_SHIFT);
    h = model_mul(m_b1, x_q) + model_mul(m_c1, m_h1) - model_mul(m_c2, m_h2);
    m_h2 = m_h1;
    m_h1 = h;
    m_x1 = count;
    act = model_mul(model_weight(pos), h);
    // no passive pull below rest length
    stretch = pos - ONE_Q;
    len_term = (stretch < 0) ? 32'sd0 : 204 * stretch;
    d_force = len_term + 136 * vel - model_mul(M_K_FORCE, m_force) + model_mul(M_K_ACT, act);
    m_force = m_force + (d_force >>> DT_SHIFT);
    r.force_val = m_force;
    r.act_val = act;
    return r;
endfunction

`endif

/* verification/muscle_tb.sv */
`default_nettype none

module muscle_tb;

    localparam int SPIKE_SHIFT = 10;
    localparam int DT_SHIFT    = 10;
    localparam int RESET_CYCLES = 5;
    // steps per test phase, weight trials take two steps each
    localparam int N_SILENT  = 6;
    localparam int N_TWITCH  = 12;
    localparam int N_WEIGHT  = 16;
    localparam int N_PASSIVE = 16;
    localparam int N_RANDOM  = 400;
    localparam int TOTAL_STEPS = N_SILENT + N_TWITCH + 2 * N_WEIGHT + N_PASSIVE + N_RANDOM;
    // a step plus at most three idle cycles
    localparam int MAX_STEP_CYCLES = 4;
    // one reset per weight trial and three more, each with a load and a drain
    localparam int N_RESETS = N_WEIGHT + 3;
    localparam int TIMEOUT_CYCLES = TOTAL_STEPS * MAX_STEP_CYCLES
                                  + N_RESETS * (RESET_CYCLES + 5) + 100;
    // twitch setting for the directed phases, a = 0.875, gain 1.0
    localparam logic [31:0] TWITCH_DECAY = 32'h0000_E000;
    localparam logic [31:0] TWITCH_GAIN  = 32'h0001_0000;

    `include "muscle_model.svh"

    // step result and the cycle its valid pulse is due
    typedef struct packed {
        logic [31:0] due;
        result_t     res;
    } expect_t;

    logic               clk;
    logic               reset;
    logic               step;
    muscle_pkg::spike_t spike_count;
    muscle_pkg::limb_t  limb;
    logic               cfg_load;
    muscle_pkg::q16_t   cfg_decay;
    muscle_pkg::q16_t   cfg_gain;
    logic               force_valid;
    muscle_pkg::q16_t   force_out;
    muscle_pkg::q16_t   activation;

    expect_t     pending[$];
    int          cycle_cnt = 0;
    int          valid_count = 0;
    int          value_errors = 0;
    int          seq_errors = 0;
    logic        reset_seen = 1'b0;
    logic [15:0] lfsr_state;

    muscle_top #(
        .SPIKE_SHIFT(SPIKE_SHIFT),
        .DT_SHIFT   (DT_SHIFT)
    ) i_muscle_top (
        .clk          (clk),
        .reset        (reset),
        .step_i       (step),
        .spike_count_i(spike_count),
        .limb_i       (limb),
        .cfg_load_i   (cfg_load),
        .cfg_decay_i  (cfg_decay),
        .cfg_gain_i   (cfg_gain),
        .force_valid_o(force_valid),
        .force_o      (force_out),
        .activation_o (activation)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////
    // random numbers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic muscle_pkg::spike_t rand_count();
        logic [31:0] v;
        v = take_bits(4);
        return v[15:0];
    endfunction

    // 0 up to and including 2.5
    function automatic muscle_pkg::q16_t rand_pos();
        return take_bits(18) % 32'd163841;
    endfunction

    // 0 up to just below 1.0
    function automatic muscle_pkg::q16_t rand_frac();
        logic [31:0] v;
        v = take_bits(16);
        return {16'd0, v[15:0]};
    endfunction

    // about -0.5 to 0.5
    function automatic muscle_pkg::q16_t rand_vel();
        logic [31:0] v;
        v = take_bits(16);
        return {{16{v[15]}}, v[15:0]};
    endfunction

    // breakpoints and their neighbours first, then random lengths
    function automatic muscle_pkg::q16_t weight_test_pos(input int trial);
        case (trial)
            0: return 32'sh0000_8000;
            1: return 32'sh0001_0000;
            2: return 32'sh0002_0000;
            3: return 32'sh0000_8001;
            4: return 32'sh0002_0001;
            5: return 32'sh0000_0000;
            6: return 32'sh0002_8000;
            default: return rand_pos();
        endcase
    endfunction

    //////////////////////////////
    // drivers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h at cycle %0d", name, got, exp, cycle_cnt);
            value_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;
    endtask

    // decay and gain take effect for steps after this cycle
    task automatic load_config(input muscle_pkg::q16_t decay, input muscle_pkg::q16_t gain);
        cfg_load  = 1'b1;
        cfg_decay = decay;
        cfg_gain  = gain;
        model_load(decay, gain);
        next_cycle();
        cfg_load = 1'b0;
    endtask

    // decay 0.75 to 0.875, gain 0.5 to 1.5
    task automatic load_random_config();
        muscle_pkg::q16_t decay;
        muscle_pkg::q16_t gain;
        decay = 32'sh0000_C000 + take_bits(13);
        gain  = 32'sh0000_8000 + take_bits(16);
        load_config(decay, gain);
    endtask

    // the valid pulse is due three edges after the one that takes the step
    task automatic do_step(input muscle_pkg::spike_t count, input muscle_pkg::q16_t pos,
                           input muscle_pkg::q16_t vel, input int gap);
        expect_t e;
        step        = 1'b1;
        spike_count = count;
        limb.pos    = pos;
        limb.vel    = vel;
        e.due = cycle_cnt + 3;
        e.res = model_step(count, pos, vel);
        pending.push_back(e);
        next_cycle();
        step = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic drain();
        while (pending.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic finish_run(input bit timed_out);
        bit short_count;
        short_count = (valid_count != TOTAL_STEPS);
        if (short_count) begin
            $display("Only %0d of %0d steps produced a checked valid pulse",
                     valid_count, TOTAL_STEPS);
        end
        $display("valid pulses: %0d, value errors: %0d, sequence errors: %0d",
                 valid_count, value_errors, seq_errors);
        if (timed_out || short_count || value_errors + seq_errors != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    // outputs are stable at the falling edge
    always @(negedge clk) begin : output_monitor
        expect_t e;
        if (reset) begin
            reset_seen = 1'b1;
        end else if (reset_seen) begin
            // first cycle out of reset, everything cleared
            reset_seen = 1'b0;
            check_value("force_valid_o", {31'd0, force_valid}, 32'd0);
            check_value("force_o", force_out, 32'd0);
            check_value("activation_o", activation, 32'd0);
        end else if (force_valid) begin
            if (pending.size() == 0) begin
                $display("Unexpected force_valid_o with no step in flight at cycle %0d",
                         cycle_cnt);
                seq_errors++;
            end else begin
                e = pending.pop_front();
                if (e.due != cycle_cnt) begin
                    $display("force_valid_o came at cycle %0d but was due at cycle %0d",
                             cycle_cnt, e.due);
                    seq_errors++;
                end
                check_value("force_o", force_out, e.res.force_val);
                check_value("activation_o", activation, e.res.act_val);
                valid_count++;
            end
        end else if (pending.size() != 0 && pending[0].due <= cycle_cnt) begin
            $display("Missing force_valid_o for the step due at cycle %0d", pending[0].due);
            seq_errors++;
            void'(pending.pop_front());
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        finish_run(1'b1);
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin : stimulus
        muscle_pkg::spike_t count;
        muscle_pkg::q16_t   pos;
        muscle_pkg::q16_t   vel;
        int                 gap;
        lfsr_state  = 16'd36;
        reset       = 1'b1;
        step        = 1'b0;
        spike_count = '0;
        limb        = '0;
        cfg_load    = 1'b0;
        cfg_decay   = '0;
        cfg_gain    = '0;

        // no config yet, spikes must not reach the activation
        apply_reset();
        for (int i = 0; i < N_SILENT; i++) begin
            do_step(rand_count() + 16'd1, ONE_Q, '0, 0);
        end
        drain();

        // single twitch at rest length, weight 1
        apply_reset();
        load_config(TWITCH_DECAY, TWITCH_GAIN);
        do_step(16'd10, ONE_Q, '0, 1);
        for (int i = 1; i < N_TWITCH; i++) begin
            do_step(16'd0, ONE_Q, '0, 1);
        end
        drain();

        // same spike history each trial, only the length changes
        for (int t = 0; t < N_WEIGHT; t++) begin
            apply_reset();
            load_config(TWITCH_DECAY, TWITCH_GAIN);
            do_step(16'd8, ONE_Q, '0, 0);
            do_step(16'd0, weight_test_pos(t), '0, 0);
            drain();
        end

        // passive force, stretched first and then shorter than rest
        apply_reset();
        for (int i = 0; i < N_PASSIVE; i++) begin
            if (i < N_PASSIVE / 2) begin
                pos = ONE_Q + 32'sd1 + rand_frac();
            end else begin
                pos = rand_frac();
            end
            do_step(16'd0, pos, '0, 0);
        end
        drain();

        // random run with a reload half way
        load_random_config();
        for (int i = 0; i < N_RANDOM; i++) begin
            if (i == N_RANDOM / 2) begin
                load_random_config();
            end
            count = rand_count();
            pos   = rand_pos();
            vel   = rand_vel();
            gap   = int'(take_bits(2));
            do_step(count, pos, vel, gap);
        end
        drain();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

/* muscle_top.f */
+incdir+verification
logic/muscle_pkg.sv
logic/sample_history.sv
logic/muscle_ctrl.sv
logic/twitch_filter.sv
logic/length_weight.sv
logic/force_integrator.sv
logic/muscle_top.sv
verification/muscle_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the muscle testbench with verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module muscle_tb -f muscle_top.f -o muscle_sim
./obj_dir/muscle_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
